// File: cpu_top.f
+incdir+sim
design/cpu_pkg.sv
design/instr_mem.sv
design/data_mem.sv
design/reg_file.sv
design/alu.sv
design/control_unit.sv
design/cpu_top.sv
sim/tb_cpu_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_cpu_top -f cpu_top.f
./obj_dir/Vtb_cpu_top 2>&1 | tee sim.log

if grep -q "Verification failed" sim.log; then
  exit 1
fi
exit 0

// File: sim/cpu_ref_model.svh
// machine state as the instruction set defines it
logic [7:0]  m_regs [4] = '{default: 8'h00};
logic [7:0]  m_dmem [16];
logic [7:0]  m_imem [256];
logic [7:0]  m_pc = 8'd0;
logic        m_c = 1'b0;
logic        m_z = 1'b0;
logic [15:0] lfsr = 16'd42705;

// taps 16 14 13 11, one step per bit
function automatic logic [7:0] take_bits(input int n);
  logic [7:0] r;
  logic       fb;
  r = 8'd0;
  for (int i = 0; i < n; i++) begin
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    r = {r[6:0], fb};
  end
  return r;
endfunction

function automatic logic [1:0] rand2();
  logic [7:0] t;
  t = take_bits(2);
  return t[1:0];
endfunction

function automatic logic [7:0] imm_value(input logic [1:0] f);
  case (f)
    2'b00:   return 8'h00;
    2'b01:   return 8'h01;
    2'b10:   return 8'hFE;
    default: return 8'hFF;
  endcase
endfunction

function automatic void set_flags(input logic [7:0] a, input logic [7:0] b);
  m_c = (a > b);
  m_z = (a == b);
endfunction

// executes the word at m_pc
function automatic void model_step();
  logic [7:0] w;
  logic [1:0] rd;
  logic [7:0] a;
  logic [7:0] b;
  logic [7:0] imm;
  w = m_imem[m_pc];
  rd = w[3:2];
  a = m_regs[rd];
  b = m_regs[w[1:0]];
  imm = imm_value(w[1:0]);
  case (w[7:4])
    4'd0:    m_regs[0] = m_dmem[w[3:0]];
    4'd1:    m_dmem[w[3:0]] = m_regs[0];
    4'd2:    m_regs[rd] = imm;
    4'd3:    m_regs[rd] = b;
    4'd4:    m_regs[rd] = a + b;
    4'd5:    m_regs[rd] = a - b;
    4'd6:    m_regs[rd] = a & b;
    4'd7:    set_flags(a, b);
    4'd8:    m_regs[rd] = a | b;
    4'd9:    m_regs[rd] = a | imm;
    4'd10:   m_regs[rd] = a ^ b;
    4'd11:   m_regs[rd] = a ^ imm;
    4'd12:   m_regs[rd] = a + imm;
    4'd13:   m_regs[rd] = a - imm;
    4'd14:   m_regs[rd] = a & imm;
    default: set_flags(a, imm);
  endcase
  m_pc = m_pc + 8'd1;
endfunction

// File: sim/tb_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top;

  localparam int RST_CYCLES = 10;
  localparam int PROG_LEN = 6 + 23 + 26 + 19;
  // run and load per instruction, one 16-word readback per test, setup slack
  localparam int BUDGET = RST_CYCLES + 5 * PROG_LEN + 5 * 48 + 200;
  localparam longint WATCHDOG_NS = 2 * 40 * BUDGET;
  localparam logic [3:0] RR_OPS [6] = '{4'd3, 4'd4, 4'd5, 4'd6, 4'd8, 4'd10};
  localparam logic [3:0] RI_OPS [5] = '{4'd9, 4'd11, 4'd12, 4'd13, 4'd14};

  logic                        clk;
  logic                        rst;
  cpu_pkg::prog_wr_t           prog;
  cpu_pkg::dmem_host_t         dmem_host;
  logic [cpu_pkg::DATA_W-1:0]  dmem_host_rdata;
  logic                        run;
  logic                        busy;
  logic                        instr_done;
  logic [cpu_pkg::IMEM_AW-1:0] pc;
  cpu_pkg::flags_t             flags;
  logic [7:0]                  prog_q [$];
  int                          errors = 0;
  int                          pass_cnt = 0;
  int                          fail_cnt = 0;

  `include "cpu_ref_model.svh"

  cpu_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Verification failed");
    $finish;
  end

  task automatic report_mismatch(input string what, input logic [7:0] got,
                                 input logic [7:0] exp);
    $display("CHECK FAILED at %0t: %s is %02h, expected %02h", $time, what, got, exp);
    errors++;
  endtask

  function automatic logic [7:0] enc(input logic [3:0] op, input logic [1:0] rd,
                                     input logic [1:0] lo);
    return {op, rd, lo};
  endfunction

  // r0..r3 to base..base+3 through r0
  function automatic void append_stores(input logic [3:0] base);
    prog_q.push_back({4'd1, base});
    for (int r = 1; r < 4; r++) begin
      prog_q.push_back(enc(4'd3, 2'd0, r[1:0]));
      prog_q.push_back({4'd1, base + r[3:0]});
    end
  endfunction

  task automatic write_dmem(input int a, input logic [7:0] d);
    @(posedge clk);
    dmem_host <= '{we: 1'b1, addr: a[3:0], wdata: d};
    @(posedge clk);
    dmem_host.we <= 1'b0;
    m_dmem[a] = d;
  endtask

  task automatic check_dmem();
    logic [7:0] got;
    for (int a = 0; a < 16; a++) begin
      @(posedge clk);
      dmem_host <= '{we: 1'b0, addr: a[3:0], wdata: 8'h00};
      @(posedge clk);
      @(negedge clk);
      got = dmem_host_rdata;
      assert (got == m_dmem[a])
        else report_mismatch($sformatf("dmem[%0d]", a), got, m_dmem[a]);
    end
  endtask

  // words go in at the current pc
  task automatic load_program();
    foreach (prog_q[i]) begin
      @(posedge clk);
      prog <= '{we: 1'b1, addr: m_pc + 8'(i), data: prog_q[i]};
      m_imem[m_pc + 8'(i)] = prog_q[i];
    end
    @(posedge clk);
    prog.we <= 1'b0;
  endtask

  task automatic run_program(input int n);
    int   seen;
    int   waited;
    logic got;
    seen = 0;
    waited = 0;
    @(posedge clk);
    run <= 1'b1;
    while (seen < n) begin
      got = 1'b0;
      while (!got && waited < 16) begin
        @(negedge clk);
        waited++;
        got = instr_done;
        assert (busy) else report_mismatch("busy while running", 8'd0, 8'd1);
      end
      if (!got) begin
        $display("no instr_done within 16 cycles at %0t, program abandoned", $time);
        errors++;
        seen = n;
        @(posedge clk);
        run <= 1'b0;
      end else begin
        assert (waited == 4) else report_mismatch("cycles per instr", 8'(waited), 8'd4);
        assert (pc == m_pc) else report_mismatch("pc at instr_done", pc, m_pc);
        model_step();
        seen++;
        // drop run on the edge that ends the last instruction
        if (seen == n) begin
          @(posedge clk);
          run <= 1'b0;
        end
        @(negedge clk);
        waited = 1;
        assert (pc == m_pc) else report_mismatch("pc after retire", pc, m_pc);
        assert (flags == {m_c, m_z})
          else report_mismatch("flags", {6'd0, flags}, {6'd0, m_c, m_z});
        assert (!(seen == n && busy)) else report_mismatch("busy after stop", 8'd1, 8'd0);
      end
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    if (errors == err_before) begin
      pass_cnt++;
      $display("%s: PASS", name);
    end else begin
      fail_cnt++;
      $display("%s: FAIL with %0d errors", name, errors - err_before);
    end
  endtask

  initial begin
    int         err0;
    int         k;
    logic [7:0] x;
    rst <= 1'b1;
    run <= 1'b0;
    prog <= '0;
    dmem_host <= '0;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;

    err0 = errors;
    @(negedge clk);
    assert (!busy && !instr_done)
      else report_mismatch("busy, instr_done", {6'd0, busy, instr_done}, 8'd0);
    assert (pc == 8'd0) else report_mismatch("pc after reset", pc, 8'd0);
    assert (flags == 2'b00) else report_mismatch("flags after reset", {6'd0, flags}, 8'd0);
    repeat (8) begin
      @(negedge clk);
      assert (pc == 8'd0 && !busy) else report_mismatch("pc while idle", pc, 8'd0);
    end
    for (int a = 0; a < 16; a++) begin
      write_dmem(a, (a[7:0] * 8'd29) ^ 8'h5C);
    end
    check_dmem();
    finish_test("test 1 reset and idle", err0);

    err0 = errors;
    prog_q.delete();
    repeat (3) prog_q.push_back(enc(4'd2, rand2(), rand2()));
    repeat (3) prog_q.push_back(enc(4'd3, rand2(), rand2()));
    load_program();
    run_program(prog_q.size());
    repeat (6) begin
      @(negedge clk);
      assert (pc == m_pc && !busy && !instr_done)
        else report_mismatch("pc while stopped", pc, m_pc);
    end
    check_dmem();
    finish_test("test 2 sequencing and stop", err0);

    err0 = errors;
    prog_q.delete();
    for (int r = 0; r < 4; r++) begin
      prog_q.push_back(enc(4'd2, r[1:0], rand2()));
    end
    repeat (12) begin
      k = take_bits(3) % 6;
      prog_q.push_back(enc(RR_OPS[k], rand2(), rand2()));
    end
    append_stores(4'd0);
    load_program();
    run_program(prog_q.size());
    check_dmem();
    finish_test("test 3 register ops", err0);

    err0 = errors;
    for (int a = 4; a < 8; a++) begin
      write_dmem(a, take_bits(8));
    end
    prog_q.delete();
    for (int r = 1; r < 4; r++) begin
      prog_q.push_back({4'd0, 4'd3 + r[3:0]});
      prog_q.push_back(enc(4'd3, r[1:0], 2'd0));
    end
    prog_q.push_back({4'd0, 4'd7});
    repeat (12) begin
      k = take_bits(3) % 5;
      prog_q.push_back(enc(RI_OPS[k], rand2(), rand2()));
    end
    append_stores(4'd8);
    load_program();
    run_program(prog_q.size());
    check_dmem();
    finish_test("test 4 loads and immediates", err0);

    err0 = errors;
    x = take_bits(8) | 8'h80;
    write_dmem(12, x);
    write_dmem(13, take_bits(8) & 8'h7F);
    prog_q.delete();
    prog_q.push_back({4'd0, 4'd12});
    prog_q.push_back(enc(4'd3, 2'd1, 2'd0));
    prog_q.push_back({4'd0, 4'd13});
    prog_q.push_back(enc(4'd3, 2'd2, 2'd0));
    prog_q.push_back(enc(4'd3, 2'd3, 2'd1));
    // greater, less, equal, then the immediate forms
    prog_q.push_back(enc(4'd7, 2'd1, 2'd2));
    prog_q.push_back(enc(4'd7, 2'd2, 2'd1));
    prog_q.push_back(enc(4'd7, 2'd1, 2'd3));
    prog_q.push_back(enc(4'd15, 2'd1, 2'b01));
    prog_q.push_back(enc(4'd2, 2'd3, 2'b11));
    prog_q.push_back(enc(4'd15, 2'd3, 2'b11));
    prog_q.push_back(enc(4'd15, 2'd2, 2'b10));
    append_stores(4'd12);
    load_program();
    run_program(prog_q.size());
    check_dmem();
    finish_test("test 5 compares", err0);

    $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
    if (errors == 0 && fail_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire cpu_pkg::prog_wr_t           prog,
  input  wire cpu_pkg::dmem_host_t         dmem_host,
  output logic [cpu_pkg::DATA_W-1:0]       dmem_host_rdata,
  input  wire logic                        run,
  output logic                             busy,
  output logic                             instr_done,
  output logic [cpu_pkg::IMEM_AW-1:0]      pc,
  output cpu_pkg::flags_t                  flags
);

  cpu_pkg::instr_t            instr;
  logic [cpu_pkg::REG_AW-1:0] rd_idx;
  logic [cpu_pkg::REG_AW-1:0] rs_idx;
  logic [cpu_pkg::DATA_W-1:0] rd_data;
  logic [cpu_pkg::DATA_W-1:0] rs_data;
  cpu_pkg::reg_wr_t           reg_wr;
  cpu_pkg::alu_op_e           alu_op;
  logic [cpu_pkg::DATA_W-1:0] alu_a;
  logic [cpu_pkg::DATA_W-1:0] alu_b;
  logic [cpu_pkg::DATA_W-1:0] alu_result;
  cpu_pkg::flags_t            alu_cmp;
  logic [cpu_pkg::DMEM_AW-1:0] dmem_addr;
  logic                       dmem_we;
  logic [cpu_pkg::DATA_W-1:0] dmem_wdata;
  logic [cpu_pkg::DATA_W-1:0] dmem_rdata;

  control_unit u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .run        (run),
    .pc         (pc),
    .instr      (instr),
    .rd_idx     (rd_idx),
    .rs_idx     (rs_idx),
    .rd_data    (rd_data),
    .rs_data    (rs_data),
    .reg_wr     (reg_wr),
    .alu_op     (alu_op),
    .alu_a      (alu_a),
    .alu_b      (alu_b),
    .alu_result (alu_result),
    .alu_cmp    (alu_cmp),
    .dmem_addr  (dmem_addr),
    .dmem_we    (dmem_we),
    .dmem_wdata (dmem_wdata),
    .dmem_rdata (dmem_rdata),
    .flags      (flags),
    .busy       (busy),
    .instr_done (instr_done)
  );

  instr_mem u_imem (
    .clk   (clk),
    .prog  (prog),
    .addr  (pc),
    .instr (instr)
  );

  data_mem u_dmem (
    .clk        (clk),
    .core_addr  (dmem_addr),
    .core_we    (dmem_we),
    .core_wdata (dmem_wdata),
    .core_rdata (dmem_rdata),
    .host       (dmem_host),
    .host_rdata (dmem_host_rdata)
  );

  reg_file u_regs (
    .clk     (clk),
    .rst     (rst),
    .rd_idx  (rd_idx),
    .rs_idx  (rs_idx),
    .rd_data (rd_data),
    .rs_data (rs_data),
    .wr      (reg_wr)
  );

  alu u_alu (
    .op     (alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result),
    .cmp    (alu_cmp)
  );

endmodule

`default_nettype wire

// File: design/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic                        run,
  output logic [cpu_pkg::IMEM_AW-1:0]      pc,
  input  wire cpu_pkg::instr_t             instr,
  output logic [cpu_pkg::REG_AW-1:0]       rd_idx,
  output logic [cpu_pkg::REG_AW-1:0]       rs_idx,
  input  wire logic [cpu_pkg::DATA_W-1:0]  rd_data,
  input  wire logic [cpu_pkg::DATA_W-1:0]  rs_data,
  output cpu_pkg::reg_wr_t                 reg_wr,
  output cpu_pkg::alu_op_e                 alu_op,
  output logic [cpu_pkg::DATA_W-1:0]       alu_a,
  output logic [cpu_pkg::DATA_W-1:0]       alu_b,
  input  wire logic [cpu_pkg::DATA_W-1:0]  alu_result,
  input  wire cpu_pkg::flags_t             alu_cmp,
  output logic [cpu_pkg::DMEM_AW-1:0]      dmem_addr,
  output logic                             dmem_we,
  output logic [cpu_pkg::DATA_W-1:0]       dmem_wdata,
  input  wire logic [cpu_pkg::DATA_W-1:0]  dmem_rdata,
  output cpu_pkg::flags_t                  flags,
  output logic                             busy,
  output logic                             instr_done
);

  typedef enum logic [1:0] {
    S_FETCH,
    S_DECODE,
    S_EXECUTE,
    S_WRITEBACK
  } state_e;

  state_e                     state;
  cpu_pkg::instr_t            ir;
  logic [cpu_pkg::DATA_W-1:0] a_q;
  logic [cpu_pkg::DATA_W-1:0] b_q;
  logic [cpu_pkg::DATA_W-1:0] alu_res_q;
  cpu_pkg::flags_t            cmp_q;
  logic [cpu_pkg::DATA_W-1:0] b_dec;
  cpu_pkg::opcode_e           dec_op;
  cpu_pkg::opcode_e           op;

  // 00 01 10 11 -> 0 1 fe ff
  function automatic logic [cpu_pkg::DATA_W-1:0] sext2(input logic [1:0] imm);
    return {{(cpu_pkg::DATA_W-1){imm[1]}}, imm[0]};
  endfunction

  function automatic logic is_imm(input cpu_pkg::opcode_e o);
    case (o)
      cpu_pkg::OP_LDI, cpu_pkg::OP_ORI, cpu_pkg::OP_XORI, cpu_pkg::OP_ADDI,
      cpu_pkg::OP_SUBI, cpu_pkg::OP_ANDI, cpu_pkg::OP_CMPI: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic is_cmp(input cpu_pkg::opcode_e o);
    return (o == cpu_pkg::OP_CMP) || (o == cpu_pkg::OP_CMPI);
  endfunction

  // decode straight from the fetched word while in DECODE
  assign dec_op = instr.rr.opcode;
  assign op     = ir.rr.opcode;

  // LD and ST always work on r0
  assign rd_idx = (dec_op == cpu_pkg::OP_LD || dec_op == cpu_pkg::OP_ST) ? '0 : instr.rr.rd;
  assign rs_idx = instr.rr.rs;
  assign b_dec  = is_imm(dec_op) ? sext2(instr.ri.imm2) : rs_data;

  always_comb begin
    case (op)
      cpu_pkg::OP_SUB, cpu_pkg::OP_SUBI: alu_op = cpu_pkg::ALU_SUB;
      cpu_pkg::OP_AND, cpu_pkg::OP_ANDI: alu_op = cpu_pkg::ALU_AND;
      cpu_pkg::OP_OR,  cpu_pkg::OP_ORI:  alu_op = cpu_pkg::ALU_OR;
      cpu_pkg::OP_XOR, cpu_pkg::OP_XORI: alu_op = cpu_pkg::ALU_XOR;
      cpu_pkg::OP_CMP, cpu_pkg::OP_CMPI: alu_op = cpu_pkg::ALU_CMP;
      default:                           alu_op = cpu_pkg::ALU_ADD;
    endcase
  end

  assign alu_a = a_q;
  assign alu_b = b_q;

  // read issued in EXECUTE, data back in WRITEBACK
  assign dmem_addr  = ir.mem.addr;
  assign dmem_we    = (state == S_WRITEBACK) && (op == cpu_pkg::OP_ST);
  assign dmem_wdata = a_q;

  always_comb begin
    reg_wr.we   = (state == S_WRITEBACK) && (op != cpu_pkg::OP_ST) && !is_cmp(op);
    reg_wr.idx  = (op == cpu_pkg::OP_LD) ? '0 : ir.rr.rd;
    case (op)
      cpu_pkg::OP_LD:                  reg_wr.data = dmem_rdata;
      cpu_pkg::OP_LDI, cpu_pkg::OP_MOV: reg_wr.data = b_q;
      default:                         reg_wr.data = alu_res_q;
    endcase
  end

  assign busy = (state != S_FETCH) || run;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= S_FETCH;
      pc         <= '0;
      flags      <= '0;
      instr_done <= 1'b0;
    end else begin
      instr_done <= (state == S_EXECUTE);
      case (state)
        S_FETCH: begin
          if (run) begin
            state <= S_DECODE;
          end
        end
        S_DECODE:  state <= S_EXECUTE;
        S_EXECUTE: state <= S_WRITEBACK;
        S_WRITEBACK: begin
          state <= S_FETCH;
          pc    <= pc + 1'b1;
          // only compares touch the flags
          if (is_cmp(op)) begin
            flags <= cmp_q;
          end
        end
        default: state <= S_FETCH;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_DECODE) begin
      ir  <= instr;
      a_q <= rd_data;
      b_q <= b_dec;
    end
    if (state == S_EXECUTE) begin
      alu_res_q <= alu_result;
      cmp_q     <= alu_cmp;
    end
  end

endmodule

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  wire cpu_pkg::alu_op_e          op,
  input  wire logic [cpu_pkg::DATA_W-1:0] a,
  input  wire logic [cpu_pkg::DATA_W-1:0] b,
  output logic [cpu_pkg::DATA_W-1:0]      result,
  output cpu_pkg::flags_t                 cmp
);

  // extra bit holds the borrow
  logic [cpu_pkg::DATA_W:0] diff;
  logic                     borrow;
  logic                     equal;

  assign diff   = {1'b0, a} - {1'b0, b};
  assign borrow = diff[cpu_pkg::DATA_W];
  assign equal  = (diff[cpu_pkg::DATA_W-1:0] == '0);

  always_comb begin
    result = '0;
    cmp    = '0;
    case (op)
      cpu_pkg::ALU_ADD: result = a + b;
      cpu_pkg::ALU_SUB: result = diff[cpu_pkg::DATA_W-1:0];
      cpu_pkg::ALU_AND: result = a & b;
      cpu_pkg::ALU_OR:  result = a | b;
      cpu_pkg::ALU_XOR: result = a ^ b;
      cpu_pkg::ALU_CMP: begin
        result = diff[cpu_pkg::DATA_W-1:0];
        // a above b means no borrow and nonzero difference
        cmp.c  = !borrow && !equal;
        cmp.z  = equal;
      end
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire logic [cpu_pkg::REG_AW-1:0] rd_idx,
  input  wire logic [cpu_pkg::REG_AW-1:0] rs_idx,
  output logic [cpu_pkg::DATA_W-1:0]      rd_data,
  output logic [cpu_pkg::DATA_W-1:0]      rs_data,
  input  wire cpu_pkg::reg_wr_t           wr
);

  logic [cpu_pkg::DATA_W-1:0] regs [cpu_pkg::REG_NUM];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < cpu_pkg::REG_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.we) begin
      regs[wr.idx] <= wr.data;
    end
  end

  // no bypass, a write shows up the cycle after
  assign rd_data = regs[rd_idx];
  assign rs_data = regs[rs_idx];

endmodule

`default_nettype wire

// File: design/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem (
  input  wire logic                        clk,
  input  wire logic [cpu_pkg::DMEM_AW-1:0] core_addr,
  input  wire logic                        core_we,
  input  wire logic [cpu_pkg::DATA_W-1:0]  core_wdata,
  output logic [cpu_pkg::DATA_W-1:0]       core_rdata,
  input  wire cpu_pkg::dmem_host_t         host,
  output logic [cpu_pkg::DATA_W-1:0]       host_rdata
);

  logic [cpu_pkg::DATA_W-1:0] mem [cpu_pkg::DMEM_DEPTH];

  // host first, core second, so the core write lands last on a collision
  always_ff @(posedge clk) begin
    if (host.we) begin
      mem[host.addr] <= host.wdata;
    end
    if (core_we) begin
      mem[core_addr] <= core_wdata;
    end
  end

  always_ff @(posedge clk) begin
    core_rdata <= mem[core_addr];
  end

  // host view, usable while the core runs
  always_ff @(posedge clk) begin
    host_rdata <= mem[host.addr];
  end

endmodule

`default_nettype wire

// File: design/instr_mem.sv
`timescale 1ns/1ps
`default_nettype none

module instr_mem (
  input  wire logic              clk,
  input  wire cpu_pkg::prog_wr_t prog,
  input  wire logic [cpu_pkg::IMEM_AW-1:0] addr,
  output cpu_pkg::instr_t        instr
);

  logic [cpu_pkg::DATA_W-1:0] mem [cpu_pkg::IMEM_DEPTH];

  // host program load
  always_ff @(posedge clk) begin
    if (prog.we) begin
      mem[prog.addr] <= prog.data;
    end
  end

  // fetch port, read every cycle
  always_ff @(posedge clk) begin
    instr <= cpu_pkg::instr_t'(mem[addr]);
  end

endmodule

`default_nettype wire

// File: design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  localparam int DATA_W = 8;
  localparam int IMEM_AW = 8;
  localparam int DMEM_AW = 4;
  localparam int REG_AW = 2;

  localparam int IMEM_DEPTH = 1 << IMEM_AW;
  localparam int DMEM_DEPTH = 1 << DMEM_AW;
  localparam int REG_NUM = 1 << REG_AW;

  typedef enum logic [3:0] {
    OP_LD   = 4'd0,
    OP_ST   = 4'd1,
    OP_LDI  = 4'd2,
    OP_MOV  = 4'd3,
    OP_ADD  = 4'd4,
    OP_SUB  = 4'd5,
    OP_AND  = 4'd6,
    OP_CMP  = 4'd7,
    OP_OR   = 4'd8,
    OP_ORI  = 4'd9,
    OP_XOR  = 4'd10,
    OP_XORI = 4'd11,
    OP_ADDI = 4'd12,
    OP_SUBI = 4'd13,
    OP_ANDI = 4'd14,
    OP_CMPI = 4'd15
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_CMP
  } alu_op_e;

  // register-register view
  typedef struct packed {
    opcode_e           opcode;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs;
  } instr_rr_t;

  // register-immediate view
  typedef struct packed {
    opcode_e           opcode;
    logic [REG_AW-1:0] rd;
    logic [1:0]        imm2;
  } instr_ri_t;

  // LD/ST view, low nibble is the data address
  typedef struct packed {
    opcode_e            opcode;
    logic [DMEM_AW-1:0] addr;
  } instr_mem_t;

  typedef union packed {
    instr_rr_t  rr;
    instr_ri_t  ri;
    instr_mem_t mem;
  } instr_t;

  typedef struct packed {
    logic c;
    logic z;
  } flags_t;

  typedef struct packed {
    logic               we;
    logic [IMEM_AW-1:0] addr;
    logic [DATA_W-1:0]  data;
  } prog_wr_t;

  typedef struct packed {
    logic               we;
    logic [DMEM_AW-1:0] addr;
    logic [DATA_W-1:0]  wdata;
  } dmem_host_t;

  typedef struct packed {
    logic              we;
    logic [REG_AW-1:0] idx;
    logic [DATA_W-1:0] data;
  } reg_wr_t;

endpackage

`default_nettype wire
